//--- mips_pkg.sv
//----------------------------------------------------------
// types and encodings for the five-stage integer core
// only the opcodes and functs listed here are decoded
//----------------------------------------------------------
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam int    NUM_REGS = 32;
    localparam word_t RESET_PC = 32'hbfc00000;

    // operand sources for the ID forwarding muxes
    localparam logic [1:0] FWD_REG = 2'd0;
    localparam logic [1:0] FWD_EX  = 2'd1;
    localparam logic [1:0] FWD_MEM = 2'd2;
    localparam logic [1:0] FWD_WB  = 2'd3;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_JR   = 6'h08,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_e;

    // second ALU operand
    typedef enum logic [1:0] {
        B_REG  = 2'd0,
        B_SIMM = 2'd1,
        B_UIMM = 2'd2
    } b_src_e;

endpackage

//--- wb_bus_if.sv
//----------------------------------------------------------
// write-back bus out of MEM/WB, one write per cycle at most
//----------------------------------------------------------
`timescale 1ns/100ps

interface wb_bus_if;
    import mips_pkg::*;

    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
    // pc of the retiring instruction, for the trace only
    word_t     pc;

    modport source (output we, output waddr, output wdata, output pc);
    modport sink   (input we, input waddr, input wdata);
    modport snoop  (input we, input waddr, input wdata);

endinterface

//--- reg_file.sv
//----------------------------------------------------------
// 2 read / 1 write register file, no reset on contents
// a read of the register written this cycle sees new data
//----------------------------------------------------------
`timescale 1ns/100ps

module reg_file (
    input  logic                clk,
    input  mips_pkg::reg_addr_t raddr_a,
    input  mips_pkg::reg_addr_t raddr_b,
    output mips_pkg::word_t     rdata_a,
    output mips_pkg::word_t     rdata_b,
    wb_bus_if.sink              wb
);
    import mips_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (wb.we && wb.waddr != '0) begin
            regs[wb.waddr] <= wb.wdata;
        end
    end

    // register 0 reads zero, then write-through, then array
    assign rdata_a = (raddr_a == '0) ? '0 :
                     (wb.we && wb.waddr == raddr_a) ? wb.wdata : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 :
                     (wb.we && wb.waddr == raddr_b) ? wb.wdata : regs[raddr_b];

endmodule

//--- alu.sv
//----------------------------------------------------------
// combinational ALU, no flags and no overflow trap
//----------------------------------------------------------
`timescale 1ns/100ps

module alu (
    input  mips_pkg::alu_op_e op,
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  logic [4:0]        shamt,
    output mips_pkg::word_t   result
);
    import mips_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};
            // shifts act on rt, which arrives on b
            ALU_SLL:  result = b << shamt;
            ALU_SRL:  result = b >> shamt;
            ALU_LUI:  result = {b[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

endmodule

//--- decoder.sv
//----------------------------------------------------------
// ID decode of the kept subset, unknown opcodes act as nop
// pc_delay is the address of the branch delay slot
//----------------------------------------------------------
`timescale 1ns/100ps

module decoder (
    input  mips_pkg::word_t     inst,
    input  mips_pkg::word_t     pc_delay,
    output mips_pkg::alu_op_e   alu_op,
    output mips_pkg::b_src_e    b_src,
    output mips_pkg::word_t     imm,
    output logic                reg_write,
    output mips_pkg::reg_addr_t dest,
    output logic                uses_rs,
    output logic                uses_rt,
    output logic                mem_read,
    output logic                mem_write,
    output logic                is_beq,
    output logic                is_bne,
    output logic                is_jump,
    output logic                is_jr,
    output mips_pkg::word_t     jump_target
);
    import mips_pkg::*;

    opcode_e opcode;
    funct_e  funct;
    logic    special;
    logic    shift;
    logic    writes;
    word_t   branch_off;

    assign opcode  = opcode_e'(inst[31:26]);
    assign funct   = funct_e'(inst[5:0]);
    assign special = (opcode == OP_SPECIAL);
    assign shift   = special && (funct == F_SLL || funct == F_SRL);

    always_comb begin
        alu_op = ALU_ADD;
        b_src  = B_SIMM;
        writes = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                b_src  = B_REG;
                writes = 1'b1;
                case (funct)
                    F_ADDU:  alu_op = ALU_ADD;
                    F_SUBU:  alu_op = ALU_SUB;
                    F_AND:   alu_op = ALU_AND;
                    F_OR:    alu_op = ALU_OR;
                    F_XOR:   alu_op = ALU_XOR;
                    F_SLT:   alu_op = ALU_SLT;
                    F_SLTU:  alu_op = ALU_SLTU;
                    F_SLL:   alu_op = ALU_SLL;
                    F_SRL:   alu_op = ALU_SRL;
                    // jr and anything unknown
                    default: writes = 1'b0;
                endcase
            end
            OP_ADDIU, OP_LW: writes = 1'b1;
            OP_ANDI: begin
                alu_op = ALU_AND;
                b_src  = B_UIMM;
                writes = 1'b1;
            end
            OP_ORI: begin
                alu_op = ALU_OR;
                b_src  = B_UIMM;
                writes = 1'b1;
            end
            OP_LUI: begin
                alu_op = ALU_LUI;
                b_src  = B_UIMM;
                writes = 1'b1;
            end
            default: writes = 1'b0;
        endcase
    end

    assign imm = (b_src == B_UIMM) ? {16'h0000, inst[15:0]} : {{16{inst[15]}}, inst[15:0]};

    assign is_beq    = (opcode == OP_BEQ);
    assign is_bne    = (opcode == OP_BNE);
    assign is_jump   = (opcode == OP_J);
    assign is_jr     = special && funct == F_JR;
    assign mem_read  = (opcode == OP_LW);
    assign mem_write = (opcode == OP_SW);

    assign uses_rs = (special && !shift) || opcode == OP_ADDIU || opcode == OP_ANDI ||
                     opcode == OP_ORI || mem_read || mem_write || is_beq || is_bne;
    assign uses_rt = (special && !is_jr) || mem_write || is_beq || is_bne;

    // rd for R-type, rt otherwise; writes to r0 are dropped here
    assign dest      = special ? inst[15:11] : inst[20:16];
    assign reg_write = writes && dest != '0;

    assign branch_off  = {{14{inst[15]}}, inst[15:0], 2'b00};
    assign jump_target = is_jump ? {pc_delay[31:28], inst[25:0], 2'b00}
                                 : pc_delay + branch_off;

endmodule

//--- hazard_unit.sv
//----------------------------------------------------------
// forwarding selects and the one-cycle stall for ID
// a branch after a load waits in ID while the load is in EX and MEM
//----------------------------------------------------------
`timescale 1ns/100ps

module hazard_unit (
    input  mips_pkg::reg_addr_t rs,
    input  mips_pkg::reg_addr_t rt,
    input  logic                uses_rs,
    input  logic                uses_rt,
    input  logic                id_is_branch,
    input  mips_pkg::reg_addr_t ex_dest,
    input  logic                ex_reg_write,
    input  logic                ex_mem_read,
    input  mips_pkg::reg_addr_t mem_dest,
    input  logic                mem_reg_write,
    input  logic                mem_mem_read,
    wb_bus_if.snoop             wb,
    output logic [1:0]          fwd_a,
    output logic [1:0]          fwd_b,
    output logic                stall
);
    import mips_pkg::*;

    logic ex_hit_a, ex_hit_b;
    logic mem_hit_a, mem_hit_b;
    logic wb_hit_a, wb_hit_b;

    assign ex_hit_a  = uses_rs && ex_reg_write && ex_dest == rs;
    assign ex_hit_b  = uses_rt && ex_reg_write && ex_dest == rt;
    assign mem_hit_a = uses_rs && mem_reg_write && mem_dest == rs;
    assign mem_hit_b = uses_rt && mem_reg_write && mem_dest == rt;
    assign wb_hit_a  = uses_rs && wb.we && wb.waddr == rs;
    assign wb_hit_b  = uses_rt && wb.we && wb.waddr == rt;

    // youngest producer wins
    assign fwd_a = ex_hit_a ? FWD_EX : mem_hit_a ? FWD_MEM : wb_hit_a ? FWD_WB : FWD_REG;
    assign fwd_b = ex_hit_b ? FWD_EX : mem_hit_b ? FWD_MEM : wb_hit_b ? FWD_WB : FWD_REG;

    // branches compare in ID, so they only take ALU results from MEM
    assign stall = ((ex_hit_a || ex_hit_b) && (id_is_branch || ex_mem_read)) ||
                   ((mem_hit_a || mem_hit_b) && id_is_branch && mem_mem_read);

endmodule

//--- fetch_unit.sv
//----------------------------------------------------------
// PC and IF/ID; the word arrives the cycle after its address
// a stall keeps the ID word in a holding register
//----------------------------------------------------------
`timescale 1ns/100ps

module fetch_unit (
    input  logic            clk,
    input  logic            resetn,
    input  logic            stall,
    input  logic            take_target,
    input  mips_pkg::word_t target,
    output mips_pkg::word_t inst_addr,
    input  mips_pkg::word_t inst_rdata,
    output mips_pkg::word_t id_inst,
    output mips_pkg::word_t id_pc,
    output mips_pkg::word_t pc_delay,
    output logic            id_valid
);
    import mips_pkg::*;

    word_t pc;
    word_t held_inst;
    logic  hold;

    assign inst_addr = pc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc <= RESET_PC;
        end else if (stall) begin
            pc <= pc;
        end else if (take_target) begin
            pc <= target;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
            hold     <= 1'b0;
        end else begin
            id_valid <= 1'b1;
            hold     <= stall;
        end
    end

    // IF/ID payload
    always_ff @(posedge clk) begin
        if (!stall) begin
            id_pc <= pc;
        end
        if (!hold) begin
            held_inst <= inst_rdata;
        end
    end

    assign id_inst  = hold ? held_inst : inst_rdata;
    assign pc_delay = id_pc + 32'd4;

endmodule

//--- cpu_top.sv
//----------------------------------------------------------
// five-stage core, branches resolve in ID with one delay slot
// both SRAMs return data one cycle after the address
//----------------------------------------------------------
`timescale 1ns/100ps

module cpu_top (
    input  logic                clk,
    input  logic                resetn,
    output mips_pkg::word_t     inst_sram_addr,
    input  mips_pkg::word_t     inst_sram_rdata,
    output logic                data_sram_we,
    output mips_pkg::word_t     data_sram_addr,
    output mips_pkg::word_t     data_sram_wdata,
    input  mips_pkg::word_t     data_sram_rdata,
    output mips_pkg::word_t     debug_wb_pc,
    output logic [3:0]          debug_wb_rf_wen,
    output mips_pkg::reg_addr_t debug_wb_rf_wnum,
    output mips_pkg::word_t     debug_wb_rf_wdata
);
    import mips_pkg::*;

    // ID
    word_t      id_inst, id_pc, pc_delay, dec_imm, dec_jump_target;
    logic       id_valid, dec_reg_write, dec_uses_rs, dec_uses_rt;
    logic       dec_mem_read, dec_mem_write, dec_is_beq, dec_is_bne, dec_is_jump, dec_is_jr;
    alu_op_e    dec_alu_op;
    b_src_e     dec_b_src;
    reg_addr_t  dec_dest;
    word_t      rf_rdata_a, rf_rdata_b, rs_val, rt_val;
    logic [1:0] fwd_a, fwd_b;
    logic       hz_stall, stall, take_target, ops_equal;
    // EX
    logic       ex_valid, ex_reg_write, ex_mem_read, ex_mem_write;
    word_t      ex_pc, ex_a, ex_b, ex_store_data, ex_mem_addr, alu_result;
    alu_op_e    ex_alu_op;
    logic [4:0] ex_shamt;
    reg_addr_t  ex_dest;
    // MEM and WB
    logic       mem_valid, mem_reg_write, mem_mem_read, wb_valid, wb_reg_write;
    word_t      mem_pc, mem_result, mem_fwd_data, wb_pc, wb_wdata;
    reg_addr_t  mem_dest, wb_dest;

    wb_bus_if wb_bus ();

    function automatic word_t fwd_pick(input logic [1:0] sel, input word_t from_rf,
                                       input word_t from_ex, input word_t from_mem,
                                       input word_t from_wb);
        case (sel)
            FWD_EX:  return from_ex;
            FWD_MEM: return from_mem;
            FWD_WB:  return from_wb;
            default: return from_rf;
        endcase
    endfunction

    //----------------------------------------------------------
    // IF and ID
    //----------------------------------------------------------
    fetch_unit i_fetch (
        .clk(clk), .resetn(resetn), .stall(stall), .take_target(take_target),
        .target(dec_is_jr ? rs_val : dec_jump_target),
        .inst_addr(inst_sram_addr), .inst_rdata(inst_sram_rdata),
        .id_inst(id_inst), .id_pc(id_pc), .pc_delay(pc_delay), .id_valid(id_valid)
    );

    decoder i_decoder (
        .inst(id_inst), .pc_delay(pc_delay), .alu_op(dec_alu_op), .b_src(dec_b_src),
        .imm(dec_imm), .reg_write(dec_reg_write), .dest(dec_dest),
        .uses_rs(dec_uses_rs), .uses_rt(dec_uses_rt), .mem_read(dec_mem_read),
        .mem_write(dec_mem_write), .is_beq(dec_is_beq), .is_bne(dec_is_bne),
        .is_jump(dec_is_jump), .is_jr(dec_is_jr), .jump_target(dec_jump_target)
    );

    reg_file i_reg_file (
        .clk(clk), .raddr_a(id_inst[25:21]), .raddr_b(id_inst[20:16]),
        .rdata_a(rf_rdata_a), .rdata_b(rf_rdata_b), .wb(wb_bus.sink)
    );

    hazard_unit i_hazard (
        .rs(id_inst[25:21]), .rt(id_inst[20:16]), .uses_rs(dec_uses_rs),
        .uses_rt(dec_uses_rt), .id_is_branch(dec_is_beq | dec_is_bne | dec_is_jr),
        .ex_dest(ex_dest), .ex_reg_write(ex_valid & ex_reg_write), .ex_mem_read(ex_mem_read),
        .mem_dest(mem_dest), .mem_reg_write(mem_valid & mem_reg_write),
        .mem_mem_read(mem_mem_read), .wb(wb_bus.snoop),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .stall(hz_stall)
    );

    // loads in MEM forward the word straight from the data SRAM
    assign mem_fwd_data = mem_mem_read ? data_sram_rdata : mem_result;
    assign rs_val = fwd_pick(fwd_a, rf_rdata_a, alu_result, mem_fwd_data, wb_bus.wdata);
    assign rt_val = fwd_pick(fwd_b, rf_rdata_b, alu_result, mem_fwd_data, wb_bus.wdata);

    assign stall       = hz_stall & id_valid;
    assign ops_equal   = (rs_val == rt_val);
    assign take_target = id_valid & ((dec_is_beq & ops_equal) | (dec_is_bne & ~ops_equal) |
                                     dec_is_jump | dec_is_jr);

    //----------------------------------------------------------
    // ID/EX, EX/MEM, MEM/WB
    //----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            // stall turns the ID/EX slot into a bubble
            ex_valid  <= id_valid & ~stall;
            mem_valid <= ex_valid;
            wb_valid  <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc         <= id_pc;
        ex_alu_op     <= dec_alu_op;
        ex_a          <= rs_val;
        ex_b          <= (dec_b_src == B_REG) ? rt_val : dec_imm;
        ex_shamt      <= id_inst[10:6];
        ex_store_data <= rt_val;
        ex_mem_addr   <= rs_val + dec_imm;
        ex_dest       <= dec_dest;
        ex_reg_write  <= dec_reg_write;
        ex_mem_read   <= dec_mem_read;
        ex_mem_write  <= dec_mem_write;

        mem_pc        <= ex_pc;
        mem_result    <= alu_result;
        mem_dest      <= ex_dest;
        mem_reg_write <= ex_reg_write;
        mem_mem_read  <= ex_mem_read;

        wb_pc         <= mem_pc;
        wb_wdata      <= mem_fwd_data;
        wb_dest       <= mem_dest;
        wb_reg_write  <= mem_reg_write;
    end

    alu i_alu (
        .op(ex_alu_op), .a(ex_a), .b(ex_b), .shamt(ex_shamt), .result(alu_result)
    );

    // data SRAM is addressed from ID/EX
    assign data_sram_we    = ex_valid & ex_mem_write;
    assign data_sram_addr  = ex_mem_addr;
    assign data_sram_wdata = ex_store_data;

    // write-back bus and trace
    assign wb_bus.we    = wb_valid & wb_reg_write;
    assign wb_bus.waddr = wb_dest;
    assign wb_bus.wdata = wb_wdata;
    assign wb_bus.pc    = wb_pc;

    assign debug_wb_pc       = wb_bus.pc;
    assign debug_wb_rf_wen   = {4{wb_bus.we}};
    assign debug_wb_rf_wnum  = wb_bus.waddr;
    assign debug_wb_rf_wdata = wb_bus.wdata;

endmodule

//--- cpu_props.sv
//----------------------------------------------------------
// pipeline invariants, bound into cpu_top
//----------------------------------------------------------
`timescale 1ns/100ps

module cpu_props (
    input logic       clk,
    input logic       resetn,
    input logic       data_sram_we,
    input logic       stall,
    input logic [3:0] debug_wb_rf_wen,
    input logic [4:0] debug_wb_rf_wnum
);

    // no store may leave the core while reset is held
    no_store_in_reset: assert property (@(posedge clk) !resetn |-> !data_sram_we)
        else $error("data_sram_we high during reset");

    // writes to register 0 are dropped in decode
    no_write_to_r0: assert property (@(posedge clk) disable iff (!resetn)
        (debug_wb_rf_wen != 4'b0000) |-> (debug_wb_rf_wnum != 5'd0))
        else $error("write-back to register 0 seen on the trace");

    single_stall: assert property (@(posedge clk) disable iff (!resetn)
        stall |=> !stall)
        else $error("stall held for two consecutive cycles");

endmodule

//--- tb_cpu.sv
//----------------------------------------------------------
// runs the program of cpu_stimulus.txt, checks trace and stores
// memories answer one cycle after the address
//----------------------------------------------------------
`timescale 1ns/100ps

module tb_cpu;

    localparam int IMEM_WORDS  = 64;
    localparam int DMEM_WORDS  = 64;
    localparam int DRAIN_CYCLES = 16;
    localparam logic [31:0] PC_BASE = 32'hbfc00000;

    logic        clk;
    logic        resetn;
    logic [31:0] inst_sram_addr, inst_sram_rdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr, data_sram_wdata, data_sram_rdata;
    logic [31:0] debug_wb_pc, debug_wb_rf_wdata;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] w_pc[$], w_val[$], s_addr[$], s_data[$];
    logic [4:0]  w_reg[$];
    int          num_inst, w_idx, s_idx, cycles, limit;
    int          value_errors, event_errors, other_errors;

    cpu_top i_dut (.*);

    bind cpu_top cpu_props i_props (
        .clk(clk), .resetn(resetn), .data_sram_we(data_sram_we), .stall(stall),
        .debug_wb_rf_wen(debug_wb_rf_wen), .debug_wb_rf_wnum(debug_wb_rf_wnum)
    );

    always #4 clk = ~clk;

    function automatic int imem_index(input logic [31:0] addr);
        return int'((addr - PC_BASE) >> 2);
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %08h actual %08h", name, expected, actual);
            value_errors++;
        end
    endtask

    //----------------------------------------------------------
    // memory models and event checks
    //----------------------------------------------------------
    always @(posedge clk) begin
        int idx;
        idx = imem_index(inst_sram_addr);
        if (idx >= 0 && idx < IMEM_WORDS) begin
            inst_sram_rdata <= imem[idx];
        end else begin
            inst_sram_rdata <= 32'h00000000;
        end
        data_sram_rdata <= dmem[data_sram_addr[7:2]];
        if (data_sram_we) begin
            dmem[data_sram_addr[7:2]] <= data_sram_wdata;
        end
        cycles <= cycles + 1;

        if (resetn && debug_wb_rf_wen != 4'b0000) begin
            if (w_idx >= w_pc.size()) begin
                $display("unexpected write-back at pc %08h after the trace ended", debug_wb_pc);
                event_errors++;
            end else begin
                compare($sformatf("trace[%0d] pc", w_idx), w_pc[w_idx], debug_wb_pc);
                // all four enable bits follow the single write enable
                compare($sformatf("trace[%0d] wen", w_idx), 32'h0000000f,
                        32'(debug_wb_rf_wen));
                compare($sformatf("trace[%0d] reg", w_idx), 32'(w_reg[w_idx]),
                        32'(debug_wb_rf_wnum));
                compare($sformatf("trace[%0d] value", w_idx), w_val[w_idx], debug_wb_rf_wdata);
                w_idx++;
            end
        end
        if (resetn && data_sram_we) begin
            if (s_idx >= s_addr.size()) begin
                $display("unexpected store to %08h", data_sram_addr);
                event_errors++;
            end else begin
                compare($sformatf("store[%0d] addr", s_idx), s_addr[s_idx], data_sram_addr);
                compare($sformatf("store[%0d] data", s_idx), s_data[s_idx], data_sram_wdata);
                s_idx++;
            end
        end
    end

    // one line per entry, '#' lines are comments
    task automatic load_stimulus();
        int          fd;
        int          code;
        string       line;
        logic [7:0]  tag;
        logic [31:0] f1, f2, f3;
        fd = $fopen("cpu_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open cpu_stimulus.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 1 && line[0] != "#") begin
                code = $sscanf(line, "%c %h %h %h", tag, f1, f2, f3);
                if (tag == "I" && num_inst < IMEM_WORDS) begin
                    imem[num_inst] = f1;
                    num_inst++;
                end else if (tag == "W") begin
                    w_pc.push_back(f1);
                    w_reg.push_back(f2[4:0]);
                    w_val.push_back(f3);
                end else if (tag == "S") begin
                    s_addr.push_back(f1);
                    s_data.push_back(f2);
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        clk = 1'b0;
        resetn = 1'b0;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        cycles = 0;
        num_inst = 0;
        w_idx = 0;
        s_idx = 0;
        value_errors = 0;
        event_errors = 0;
        other_errors = 0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = 32'h00000000;
        end
        // fill pattern from the full word address
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = 32'(i) * 32'h9e3779b1;
        end
        load_stimulus();
        limit = 8 * num_inst + 50;

        repeat (3) @(posedge clk);
        resetn <= 1'b1;

        while ((w_idx < w_pc.size() || s_idx < s_addr.size()) && cycles < limit) begin
            @(posedge clk);
        end
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, %0d trace and %0d store entries missing",
                     cycles, w_pc.size() - w_idx, s_addr.size() - s_idx);
            other_errors++;
        end else begin
            // the program spins in its last loop, nothing more should retire
            repeat (DRAIN_CYCLES) @(posedge clk);
        end

        $display("errors: %0d value, %0d event, %0d other", value_errors, event_errors,
                 other_errors);
        if (value_errors + event_errors + other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- cpu_stimulus.txt
# I <word> : program from 0xbfc00000 in address order
# W <pc> <reg> <value> : write-back trace ; S <addr> <data> : stores
I 24010005
I 24220003
I 00221821
I 00612023
I 3c058000
I 34a500f0
I 00a1302a
I 00a1382b
I 00a34024
I 00a24026
I 30a900ff
I 00095100
I 00055f02
I 00220021
I 00016025
I 240d0100
I adaa0004
I 8dae0004
I 25cf0001
I adaf0008
I 24100003
I 16000002
I 24110007
I 24110099
I 12000002
I 24120011
I 26520001
I 12520002
I 24130021
I 24130055
I 3c14bfc0
I 36940090
I 02800008
I 24150031
I 24150066
I 24150077
I 0bf00028
I 24160041
I 24160088
I 24160089
I 02d5b821
I 0bf00029
I 00000000
W bfc00000 01 00000005
W bfc00004 02 00000008
W bfc00008 03 0000000d
W bfc0000c 04 00000008
W bfc00010 05 80000000
W bfc00014 05 800000f0
W bfc00018 06 00000001
W bfc0001c 07 00000000
W bfc00020 08 00000000
W bfc00024 08 800000f8
W bfc00028 09 000000f0
W bfc0002c 0a 00000f00
W bfc00030 0b 00000008
W bfc00038 0c 00000005
W bfc0003c 0d 00000100
W bfc00044 0e 00000f00
W bfc00048 0f 00000f01
W bfc00050 10 00000003
W bfc00058 11 00000007
W bfc00064 12 00000011
W bfc00068 12 00000012
W bfc00070 13 00000021
W bfc00078 14 bfc00000
W bfc0007c 14 bfc00090
W bfc00084 15 00000031
W bfc00094 16 00000041
W bfc000a0 17 00000072
S 00000104 00000f00
S 00000108 00000f01

//--- files.f
mips_pkg.sv
wb_bus_if.sv
reg_file.sv
alu.sv
decoder.sv
hazard_unit.sv
fetch_unit.sv
cpu_top.sv
cpu_props.sv
tb_cpu.sv

//--- run.sh
#!/bin/sh
# build and run the core testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_cpu -f files.f -o sim_cpu
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" sim.log; then
    exit 0
fi
exit 1
